/* logic/rv_params.svh */
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// address of the first instruction fetch after reset
`define RV_RESET_ADDR 32'h0000_0000

// data and address width
`define RV_XLEN 32

// architectural register count
`define RV_NREGS 32

// register index width as log2 of RV_NREGS
`define RV_REG_AW 5

`endif

/* logic/rv_pkg.sv */
`include "rv_params.svh"

package rv_pkg;

    // multicycle sequence with one instruction in flight
    typedef enum logic [1:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_WRITEBACK
    } state_t;

    // major opcodes handled by the decoder
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_t;

    // compares give 0 or 1 in bit 0
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_EQ,
        ALU_NE,
        ALU_LT,
        ALU_GE,
        ALU_LTU,
        ALU_GEU
    } alu_op_t;

    typedef enum logic [1:0] {
        PC_SEQ,
        PC_BRANCH,
        PC_JAL,
        PC_JALR
    } pc_src_t;

    typedef enum logic {
        RES_ALU,
        RES_PC_PLUS4
    } res_src_t;

    typedef enum logic {
        OP1_REG,
        OP1_PC
    } op1_sel_t;

    typedef enum logic {
        OP2_REG,
        OP2_IMM
    } op2_sel_t;

    typedef struct packed {
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   imm;
        alu_op_t               alu_op;
        op1_sel_t              op1_sel;
        op2_sel_t              op2_sel;
        res_src_t              res_src;
        pc_src_t               pc_src;
        logic                  reg_write;
    } ctrl_word_t;

    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic [`RV_XLEN-1:0] adr;
    } bus_req_t;

    typedef struct packed {
        logic                  valid;
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_XLEN-1:0]   instr;
        logic                  reg_write;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   wdata;
    } retire_t;

endpackage

/* logic/rv_control.sv */
`timescale 1ns/1ps

module rv_control
    import rv_pkg::*;
(
    input  logic i_clk,
    input  logic i_reset_n,
    input  logic i_bus_ack,
    output logic o_fetching,
    output logic o_ir_load,
    output logic o_exec_en,
    output logic o_commit
);

    state_t state;
    state_t state_nxt;

    always_comb
    begin
        case (state)
            ST_FETCH:     state_nxt = i_bus_ack ? ST_DECODE : ST_FETCH;
            ST_DECODE:    state_nxt = ST_EXECUTE;
            ST_EXECUTE:   state_nxt = ST_WRITEBACK;
            ST_WRITEBACK: state_nxt = ST_FETCH;
            default:      state_nxt = ST_FETCH;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            state <= ST_FETCH;
        else
            state <= state_nxt;
    end

    // one strobe per state so no other module decodes it
    assign o_fetching = (state == ST_FETCH);
    assign o_ir_load  = o_fetching && i_bus_ack;
    assign o_exec_en  = (state == ST_EXECUTE);
    assign o_commit   = (state == ST_WRITEBACK);

endmodule

/* logic/rv_fetch.sv */
`timescale 1ns/1ps

`include "rv_params.svh"

module rv_fetch
    import rv_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  logic                i_fetching,
    input  logic                i_ir_load,
    input  logic                i_commit,
    input  logic [`RV_XLEN-1:0] i_bus_dat,
    input  ctrl_word_t          i_ctrl,
    input  logic                i_taken,
    input  logic [`RV_XLEN-1:0] i_rs1_data,
    output bus_req_t            o_bus,
    output logic [`RV_XLEN-1:0] o_pc,
    output logic [`RV_XLEN-1:0] o_instr
);

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] ir;
    logic [`RV_XLEN-1:0] pc_plus4;
    logic [`RV_XLEN-1:0] pc_target;
    logic [`RV_XLEN-1:0] jalr_sum;
    logic [`RV_XLEN-1:0] next_pc;

    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + i_ctrl.imm;
    assign jalr_sum  = i_rs1_data + i_ctrl.imm;

    always_comb
    begin
        case (i_ctrl.pc_src)
            PC_BRANCH: next_pc = i_taken ? pc_target : pc_plus4;
            PC_JAL:    next_pc = pc_target;
            PC_JALR:   next_pc = {jalr_sum[`RV_XLEN-1:1], 1'b0};
            default:   next_pc = pc_plus4;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            pc <= `RV_RESET_ADDR;
        else if (i_commit)
            pc <= next_pc;
    end

    // instruction word captured on the ack cycle
    always_ff @(posedge i_clk)
    begin
        if (i_ir_load)
            ir <= i_bus_dat;
    end

    // cyc and stb held for the whole fetch state
    assign o_bus.cyc = i_fetching;
    assign o_bus.stb = i_fetching;
    assign o_bus.adr = pc;
    assign o_pc      = pc;
    assign o_instr   = ir;

endmodule

/* logic/rv_decode.sv */
`timescale 1ns/1ps

`include "rv_params.svh"

module rv_decode
    import rv_pkg::*;
(
    input  logic [`RV_XLEN-1:0] i_instr,
    output ctrl_word_t          o_ctrl
);

    opcode_t             opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;

    assign opcode = opcode_t'(i_instr[6:0]);
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    assign imm_i = {{21{i_instr[31]}}, i_instr[30:20]};
    assign imm_b = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'h000};
    assign imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};

    always_comb
    begin
        // defaults describe a no-op that falls through to pc+4
        o_ctrl.rs1       = i_instr[19:15];
        o_ctrl.rs2       = i_instr[24:20];
        o_ctrl.rd        = i_instr[11:7];
        o_ctrl.imm       = imm_i;
        o_ctrl.alu_op    = ALU_ADD;
        o_ctrl.op1_sel   = OP1_REG;
        o_ctrl.op2_sel   = OP2_REG;
        o_ctrl.res_src   = RES_ALU;
        o_ctrl.pc_src    = PC_SEQ;
        o_ctrl.reg_write = 1'b0;

        case (opcode)
            OPC_LUI:
            begin
                // x0 + imm
                o_ctrl.rs1       = '0;
                o_ctrl.imm       = imm_u;
                o_ctrl.op2_sel   = OP2_IMM;
                o_ctrl.reg_write = 1'b1;
            end
            OPC_AUIPC:
            begin
                o_ctrl.imm       = imm_u;
                o_ctrl.op1_sel   = OP1_PC;
                o_ctrl.op2_sel   = OP2_IMM;
                o_ctrl.reg_write = 1'b1;
            end
            OPC_JAL:
            begin
                o_ctrl.imm       = imm_j;
                o_ctrl.res_src   = RES_PC_PLUS4;
                o_ctrl.pc_src    = PC_JAL;
                o_ctrl.reg_write = 1'b1;
            end
            OPC_JALR:
            begin
                if (funct3 == 3'b000)
                begin
                    o_ctrl.res_src   = RES_PC_PLUS4;
                    o_ctrl.pc_src    = PC_JALR;
                    o_ctrl.reg_write = 1'b1;
                end
            end
            OPC_BRANCH:
            begin
                o_ctrl.imm    = imm_b;
                o_ctrl.pc_src = PC_BRANCH;
                case (funct3)
                    3'b000:  o_ctrl.alu_op = ALU_EQ;
                    3'b001:  o_ctrl.alu_op = ALU_NE;
                    3'b100:  o_ctrl.alu_op = ALU_LT;
                    3'b101:  o_ctrl.alu_op = ALU_GE;
                    3'b110:  o_ctrl.alu_op = ALU_LTU;
                    3'b111:  o_ctrl.alu_op = ALU_GEU;
                    default: o_ctrl.pc_src = PC_SEQ;
                endcase
            end
            OPC_OP_IMM:
            begin
                o_ctrl.op2_sel   = OP2_IMM;
                o_ctrl.reg_write = 1'b1;
                case (funct3)
                    3'b000: o_ctrl.alu_op = ALU_ADD;
                    3'b010: o_ctrl.alu_op = ALU_LT;
                    3'b011: o_ctrl.alu_op = ALU_LTU;
                    3'b100: o_ctrl.alu_op = ALU_XOR;
                    3'b110: o_ctrl.alu_op = ALU_OR;
                    3'b111: o_ctrl.alu_op = ALU_AND;
                    3'b001:
                    begin
                        o_ctrl.alu_op    = ALU_SLL;
                        o_ctrl.reg_write = (funct7 == 7'b0000000);
                    end
                    default:
                    begin
                        // bit 30 picks srai over srli
                        o_ctrl.alu_op    = funct7[5] ? ALU_SRA : ALU_SRL;
                        o_ctrl.reg_write = ((funct7 & 7'b1011111) == 7'b0000000);
                    end
                endcase
            end
            OPC_OP:
            begin
                o_ctrl.reg_write = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: o_ctrl.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: o_ctrl.alu_op = ALU_SUB;
                    {7'b0000000, 3'b001}: o_ctrl.alu_op = ALU_SLL;
                    {7'b0000000, 3'b010}: o_ctrl.alu_op = ALU_LT;
                    {7'b0000000, 3'b011}: o_ctrl.alu_op = ALU_LTU;
                    {7'b0000000, 3'b100}: o_ctrl.alu_op = ALU_XOR;
                    {7'b0000000, 3'b101}: o_ctrl.alu_op = ALU_SRL;
                    {7'b0100000, 3'b101}: o_ctrl.alu_op = ALU_SRA;
                    {7'b0000000, 3'b110}: o_ctrl.alu_op = ALU_OR;
                    {7'b0000000, 3'b111}: o_ctrl.alu_op = ALU_AND;
                    default:              o_ctrl.reg_write = 1'b0;
                endcase
            end
            default:
            begin
                o_ctrl.reg_write = 1'b0;
            end
        endcase
    end

endmodule

/* logic/rv_execute.sv */
`timescale 1ns/1ps

`include "rv_params.svh"

module rv_execute
    import rv_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_exec_en,
    input  ctrl_word_t          i_ctrl,
    input  logic [`RV_XLEN-1:0] i_pc,
    input  logic [`RV_XLEN-1:0] i_rs1_data,
    input  logic [`RV_XLEN-1:0] i_rs2_data,
    output logic [`RV_XLEN-1:0] o_result,
    output logic                o_taken
);

    logic [`RV_XLEN-1:0] op1;
    logic [`RV_XLEN-1:0] op2;
    logic [4:0]          shamt;
    logic                lt_s;
    logic                lt_u;
    logic [`RV_XLEN-1:0] alu_res;
    logic [`RV_XLEN-1:0] res_mux;

    assign op1   = (i_ctrl.op1_sel == OP1_PC) ? i_pc : i_rs1_data;
    assign op2   = (i_ctrl.op2_sel == OP2_IMM) ? i_ctrl.imm : i_rs2_data;
    assign shamt = op2[4:0];
    assign lt_s  = $signed(op1) < $signed(op2);
    assign lt_u  = op1 < op2;

    always_comb
    begin
        case (i_ctrl.alu_op)
            ALU_SUB: alu_res = op1 - op2;
            ALU_XOR: alu_res = op1 ^ op2;
            ALU_OR:  alu_res = op1 | op2;
            ALU_AND: alu_res = op1 & op2;
            ALU_SLL: alu_res = op1 << shamt;
            ALU_SRL: alu_res = op1 >> shamt;
            ALU_SRA: alu_res = $unsigned($signed(op1) >>> shamt);
            ALU_EQ:  alu_res = {31'b0, op1 == op2};
            ALU_NE:  alu_res = {31'b0, op1 != op2};
            ALU_LT:  alu_res = {31'b0, lt_s};
            ALU_GE:  alu_res = {31'b0, !lt_s};
            ALU_LTU: alu_res = {31'b0, lt_u};
            ALU_GEU: alu_res = {31'b0, !lt_u};
            default: alu_res = op1 + op2;
        endcase
    end

    // link address for jal and jalr
    assign res_mux = (i_ctrl.res_src == RES_PC_PLUS4) ? (i_pc + 32'd4) : alu_res;

    // held until the next execute and read in writeback
    always_ff @(posedge i_clk)
    begin
        if (i_exec_en)
        begin
            o_result <= res_mux;
            o_taken  <= alu_res[0];
        end
    end

endmodule

/* logic/rv_regs.sv */
`timescale 1ns/1ps

`include "rv_params.svh"

module rv_regs
(
    input  logic                  i_clk,
    input  logic                  i_reset_n,
    input  logic [`RV_REG_AW-1:0] i_rs1,
    input  logic [`RV_REG_AW-1:0] i_rs2,
    input  logic [`RV_REG_AW-1:0] i_rd,
    input  logic                  i_commit,
    input  logic                  i_reg_write,
    input  logic [`RV_XLEN-1:0]   i_wdata,
    output logic [`RV_XLEN-1:0]   o_rs1_data,
    output logic [`RV_XLEN-1:0]   o_rs2_data
);

    logic [`RV_XLEN-1:0] regs [`RV_NREGS];
    logic                wr_en;

    // x0 is never written
    assign wr_en = i_commit && i_reg_write && (i_rd != '0);

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            for (int i = 0; i < `RV_NREGS; i++)
                regs[i] <= '0;
        end
        else if (wr_en)
        begin
            regs[i_rd] <= i_wdata;
        end
    end

    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

/* logic/rv_core.sv */
`timescale 1ns/1ps

`include "rv_params.svh"

module rv_core
    import rv_pkg::*;
(
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  logic [`RV_XLEN-1:0] i_bus_dat,
    input  logic                i_bus_ack,
    output bus_req_t            o_bus,
    output retire_t             o_retire
);

    logic                fetching;
    logic                ir_load;
    logic                exec_en;
    logic                commit;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] instr;
    ctrl_word_t          ctrl;
    logic [`RV_XLEN-1:0] result;
    logic                taken;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;

    rv_control u_control
    (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_bus_ack  (i_bus_ack),
        .o_fetching (fetching),
        .o_ir_load  (ir_load),
        .o_exec_en  (exec_en),
        .o_commit   (commit)
    );

    rv_fetch u_fetch
    (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .i_fetching (fetching),
        .i_ir_load  (ir_load),
        .i_commit   (commit),
        .i_bus_dat  (i_bus_dat),
        .i_ctrl     (ctrl),
        .i_taken    (taken),
        .i_rs1_data (rs1_data),
        .o_bus      (o_bus),
        .o_pc       (pc),
        .o_instr    (instr)
    );

    rv_decode u_decode
    (
        .i_instr (instr),
        .o_ctrl  (ctrl)
    );

    rv_execute u_execute
    (
        .i_clk      (i_clk),
        .i_exec_en  (exec_en),
        .i_ctrl     (ctrl),
        .i_pc       (pc),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .o_result   (result),
        .o_taken    (taken)
    );

    rv_regs u_regs
    (
        .i_clk       (i_clk),
        .i_reset_n   (i_reset_n),
        .i_rs1       (ctrl.rs1),
        .i_rs2       (ctrl.rs2),
        .i_rd        (ctrl.rd),
        .i_commit    (commit),
        .i_reg_write (ctrl.reg_write),
        .i_wdata     (result),
        .o_rs1_data  (rs1_data),
        .o_rs2_data  (rs2_data)
    );

    // one record per instruction in the writeback cycle
    assign o_retire = '{
        valid:     commit,
        pc:        pc,
        instr:     instr,
        reg_write: ctrl.reg_write,
        rd:        ctrl.rd,
        wdata:     result
    };

endmodule

/* test/rv_core_tb.sv */
`timescale 1ns/1ps

`include "rv_params.svh"

module rv_core_tb
    import rv_pkg::*;
();

    typedef struct packed {
        logic [`RV_XLEN-1:0]   pc;
        logic                  reg_write;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   wdata;
    } exp_retire_t;

    logic                i_clk = 1'b0;
    logic                i_reset_n;
    logic [`RV_XLEN-1:0] i_bus_dat;
    logic                i_bus_ack;
    bus_req_t            o_bus;
    retire_t             o_retire;

    logic [`RV_XLEN-1:0] mem [256];
    exp_retire_t         exp_q[$];
    logic [31:0]         rng_state = 32'ha1b57c98;

    int                  cycle;
    int                  ack_cycle;
    int                  acks_open;
    int                  ret_idx;
    int                  value_errors;
    int                  other_errors;
    int                  limit_ns;
    bit                  loaded;
    bit                  load_ok;
    bit                  req_open;
    logic [`RV_XLEN-1:0] req_addr;
    logic [1:0]          delay_left;

    rv_core dut
    (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_bus_dat (i_bus_dat),
        .i_bus_ack (i_bus_ack),
        .o_bus     (o_bus),
        .o_retire  (o_retire)
    );

    always #50 i_clk = ~i_clk;

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic fill_memory();
        for (int i = 0; i < 256; i++)
            mem[i] = (32'(i) << 2) ^ 32'h5a5a_5a5a;
    endtask

    task automatic load_testdata(output bit ok);
        int          fd;
        int          n;
        string       line;
        byte         tag;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        exp_retire_t e;
        ok = 1'b0;
        fd = $fopen("test/rv_testdata.txt", "r");
        if (fd != 0)
        begin
            ok = 1'b1;
            while ($fgets(line, fd) != 0)
            begin
                if (line.len() < 3)
                    continue;
                tag = line.getc(0);
                if (tag == "I")
                begin
                    n = $sscanf(line.substr(2, line.len() - 1), "%h %h", f0, f1);
                    if (n == 2)
                        mem[f0[9:2]] = f1;
                    else
                        ok = 1'b0;
                end
                else if (tag == "E")
                begin
                    n = $sscanf(line.substr(2, line.len() - 1), "%h %h %h %h", f0, f1, f2, f3);
                    e.pc        = f0;
                    e.reg_write = f1[0];
                    e.rd        = f2[4:0];
                    e.wdata     = f3;
                    if (n == 4)
                        exp_q.push_back(e);
                    else
                        ok = 1'b0;
                end
            end
            $fclose(fd);
            if (exp_q.size() == 0)
                ok = 1'b0;
        end
    endtask

    task automatic check_retire();
        exp_retire_t e;
        if (o_retire.valid === 1'b1)
        begin
            e = exp_q[ret_idx];
            if (acks_open != 1)
            begin
                $display("retire %0d came without exactly one ack before it", ret_idx);
                other_errors++;
            end
            if (cycle - ack_cycle != 3)
            begin
                $display("retire %0d came %0d cycles after its ack instead of 3",
                         ret_idx, cycle - ack_cycle);
                other_errors++;
            end
            acks_open = 0;
            if (o_retire.pc !== e.pc)
            begin
                $display("ERROR retire %0d pc: expected %h, actual %h",
                         ret_idx, e.pc, o_retire.pc);
                value_errors++;
            end
            if (o_retire.instr !== mem[e.pc[9:2]])
            begin
                $display("ERROR retire %0d instr: expected %h, actual %h",
                         ret_idx, mem[e.pc[9:2]], o_retire.instr);
                value_errors++;
            end
            if (o_retire.reg_write !== e.reg_write)
            begin
                $display("ERROR retire %0d reg_write: expected %b, actual %b",
                         ret_idx, e.reg_write, o_retire.reg_write);
                value_errors++;
            end
            // rd and wdata carry meaning only for a register write
            if (e.reg_write && o_retire.rd !== e.rd)
            begin
                $display("ERROR retire %0d rd: expected %0d, actual %0d",
                         ret_idx, e.rd, o_retire.rd);
                value_errors++;
            end
            if (e.reg_write && o_retire.wdata !== e.wdata)
            begin
                $display("ERROR retire %0d wdata: expected %h, actual %h",
                         ret_idx, e.wdata, o_retire.wdata);
                value_errors++;
            end
            ret_idx++;
        end
    endtask

    // fetch bus slave acking after 0 to 3 cycles
    task automatic bus_step();
        logic [31:0] rnd;
        if (i_bus_ack)
        begin
            i_bus_ack = 1'b0;
            i_bus_dat = '0;
            if (o_bus.stb !== 1'b0)
            begin
                $display("stb still high in the cycle after ack at cycle %0d", cycle);
                other_errors++;
            end
        end
        else if (o_bus.stb === 1'b1)
        begin
            if (o_bus.cyc !== 1'b1)
            begin
                $display("cyc low while stb is high at cycle %0d", cycle);
                other_errors++;
            end
            if (!req_open)
            begin
                rnd        = next_random();
                req_open   = 1'b1;
                req_addr   = o_bus.adr;
                delay_left = rnd[31:30];
            end
            else if (o_bus.adr !== req_addr)
            begin
                $display("ERROR fetch address hold: expected %h, actual %h", req_addr, o_bus.adr);
                value_errors++;
            end
            if (delay_left == 2'd0)
            begin
                if (acks_open != 0)
                begin
                    $display("new fetch acknowledged before the previous one retired");
                    other_errors++;
                end
                i_bus_dat = mem[req_addr[9:2]];
                i_bus_ack = 1'b1;
                req_open  = 1'b0;
                ack_cycle = cycle;
                acks_open++;
            end
            else
            begin
                delay_left = delay_left - 2'd1;
            end
        end
        else if (req_open)
        begin
            $display("stb dropped before ack at cycle %0d", cycle);
            other_errors++;
        end
    endtask

    initial
    begin
        i_reset_n = 1'b0;
        i_bus_ack = 1'b0;
        i_bus_dat = '0;
        cycle     = 0;
        ack_cycle = -100;
        acks_open = 0;
        ret_idx   = 0;
        req_open  = 1'b0;
        fill_memory();
        load_testdata(load_ok);
        if (!load_ok)
        begin
            $display("could not read test/rv_testdata.txt or it holds no usable records");
            $display("Finished with errors");
            $finish;
        end
        else
        begin
            limit_ns = (exp_q.size() * 8 * 100 + 3 * 100) * 2;
            loaded   = 1'b1;
            repeat (3)
            begin
                @(negedge i_clk);
                cycle++;
                if (o_retire.valid !== 1'b0)
                begin
                    $display("retire valid during reset at cycle %0d", cycle);
                    other_errors++;
                end
            end
            i_reset_n = 1'b1;
            if (o_bus.stb !== 1'b1)
            begin
                $display("first cycle after reset is not a fetch");
                other_errors++;
            end
            while (ret_idx < exp_q.size())
            begin
                check_retire();
                bus_step();
                @(negedge i_clk);
                cycle++;
            end
            $display("checked %0d of %0d retires: %0d value errors, %0d other errors",
                     ret_idx, exp_q.size(), value_errors, other_errors);
            if (value_errors == 0 && other_errors == 0)
                $display("Finished with no errors");
            else
                $display("Finished with errors");
            $finish;
        end
    end

    // twice 8 cycles per retire plus reset
    initial
    begin
        wait (loaded);
        #(limit_ns);
        $display("watchdog expired after %0d ns with %0d of %0d retires seen",
                 limit_ns, ret_idx, exp_q.size());
        $display("%0d value errors and %0d other errors before the watchdog",
                 value_errors, other_errors);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* test/rv_testdata.txt */
# I <byte address> <instruction word>
# E <pc> <reg_write> <rd> <wdata>, rd and wdata are checked only when reg_write is 1
I 00000000 00500093
I 00000004 ffd00113
I 00000008 002081b3
I 0000000c 40208233
I 00000010 00f14293
I 00000014 0040e333
I 00000018 0ff17393
I 0000001c 00409413
I 00000020 40115493
I 00000024 00115533
I 00000028 001125b3
I 0000002c fff0b613
I 00000030 123456b7
I 00000034 00001717
I 00000038 00108463
I 00000040 00109463
I 00000044 00114463
I 0000004c 00117463
I 00000054 00116463
I 00000058 0020d463
I 00000060 008007ef
I 00000068 06c08867
I 00000070 00500013
I 00000074 000008b3
I 00000078 ffffffff
I 0000007c 00108913
E 00000000 1 01 00000005
E 00000004 1 02 fffffffd
E 00000008 1 03 00000002
E 0000000c 1 04 00000008
E 00000010 1 05 fffffff2
E 00000014 1 06 0000000d
E 00000018 1 07 000000fd
E 0000001c 1 08 00000050
E 00000020 1 09 fffffffe
E 00000024 1 0a 07ffffff
E 00000028 1 0b 00000001
E 0000002c 1 0c 00000001
E 00000030 1 0d 12345000
E 00000034 1 0e 00001034
E 00000038 0 00 00000000
E 00000040 0 00 00000000
E 00000044 0 00 00000000
E 0000004c 0 00 00000000
E 00000054 0 00 00000000
E 00000058 0 00 00000000
E 00000060 1 0f 00000064
E 00000068 1 10 0000006c
E 00000070 1 00 00000005
E 00000074 1 11 00000000
E 00000078 0 00 00000000
E 0000007c 1 12 00000006

/* project.f */
+incdir+logic
logic/rv_pkg.sv
logic/rv_control.sv
logic/rv_fetch.sv
logic/rv_decode.sv
logic/rv_execute.sv
logic/rv_regs.sv
logic/rv_core.sv
test/rv_core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module rv_core_tb -f project.f

out=$(./obj_dir/Vrv_core_tb)
echo "$out"

if echo "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1
